/* flist.f */
src/nnPkg.sv
src/fpMul.sv
src/fpAdd.sv
src/neuronUnit.sv
src/paramStore.sv
src/hostBridge.sv
src/nnLayerTop.sv
testbench/tbLayer.sv

/* run.sh */
#!/bin/sh
# build and run the layer testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f flist.f --top-module tbLayer -Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

./obj_dir/simv > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "TB FAILED" "$LOG"; then
	exit 1
fi
exit 0

/* testbench/tbLayer.sv */
`timescale 1ns/100ps

module tbLayer import nnPkg::*; ();

	localparam int NN = 2;
	localparam int RESET_CYC = 16;
	localparam int TEST_CYC = 2000;  // longest test, rounded up
	localparam int NUM_TESTS = 6;
	localparam int MAX_CYC = (NUM_TESTS * TEST_CYC * 5) / 3; // 20000 with headroom
	localparam logic [7:0] REG = 8'h80; // adr[REG_SPACE]

	logic              clk;
	logic              arstN;
	logic              cyc;
	logic              stb;
	logic              we;
	logic [7:0]        adr;
	logic [WORD_W-1:0] datW;
	logic [WORD_W-1:0] datR;
	logic              ack;

	logic [31:0] seed;
	logic [31:0] shadow [128]; // host view of the store
	int          actH [FAN_IN];     // values in halves
	int          wH [NN][FAN_IN];
	int          biasH [NN];
	int          cycles;
	int          checks;
	int          errors;

	nnLayerTop #(.NUM_NEURONS(NN)) u_dut (
		.clk(clk), .arstN(arstN),
		.cyc(cyc), .stb(stb), .we(we), .adr(adr),
		.datW(datW), .datR(datR), .ack(ack)
	);

	initial
		clk = 1'b0;
	always #2 clk = ~clk;

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= MAX_CYC)
		begin
			$display("timeout, run exceeded %0d cycles", MAX_CYC);
			$display("TB FAILED");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////

	function automatic logic [31:0] lcgStep(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// signed fixed point with fb fraction bits to float bits
	function automatic logic [31:0] fixToFloat(input int q, input int fb);
		logic        sgn;
		logic [31:0] mag;
		logic [31:0] frac;
		int          msb;
		if (q == 0)
			return 32'd0;
		sgn = (q < 0);
		mag = sgn ? -q : q;
		msb = 0;
		for (int i = 0; i < 24; i++)
			if (mag[i])
				msb = i;
		frac = mag << (23 - msb); // hidden one drops out below
		return {sgn, 8'(127 + msb - fb), frac[22:0]};
	endfunction

	// exact dot product in quarters, then rectifier
	function automatic logic [31:0] refBits(input int n);
		int q;
		q = 2 * biasH[n];
		for (int i = 0; i < FAN_IN; i++)
			q += actH[i] * wH[n][i];
		if (q <= 0)
			return 32'd0;
		return fixToFloat(q, 2);
	endfunction

	task automatic checkVal(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("[FAIL] %s got %08h expected %08h", name, got, exp);
		end
	endtask

	task automatic wbWrite(input logic [7:0] a, input logic [31:0] d);
		@(negedge clk);
		cyc = 1'b1;
		stb = 1'b1;
		we = 1'b1;
		adr = a;
		datW = d;
		do @(negedge clk); while (!ack);
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		if (!a[REG_SPACE])
			shadow[a[6:0]] = d;
	endtask

	task automatic wbRead(input logic [7:0] a, output logic [31:0] d);
		@(negedge clk);
		cyc = 1'b1;
		stb = 1'b1;
		we = 1'b0;
		adr = a;
		do @(negedge clk); while (!ack);
		d = datR;
		cyc = 1'b0;
		stb = 1'b0;
	endtask

	task automatic loadActs();
		for (int i = 0; i < FAN_IN; i++)
			wbWrite(8'(ACT_BASE + i), fixToFloat(actH[i], 1));
	endtask

	task automatic loadNeuron(input int n);
		for (int i = 0; i < FAN_IN; i++)
			wbWrite(8'(NEURON_BASE + n * REGION_W + i), fixToFloat(wH[n][i], 1));
		wbWrite(8'(NEURON_BASE + n * REGION_W + FAN_IN), fixToFloat(biasH[n], 1));
	endtask

	// start, then poll STATUS, optionally reading store words in between
	task automatic runNeurons(input logic [31:0] mask, input bit pollStore);
		logic [31:0] st;
		logic [31:0] d;
		int          k;
		k = 0;
		wbWrite(REG | 8'(CTRL_OFS), mask);
		wbRead(REG | 8'(STATUS_OFS), st);
		checkVal("STATUS busy", st & mask, mask);
		while ((st & mask) != 0)
		begin
			if (pollStore)
			begin
				wbRead(8'(k), d);
				checkVal("store word", d, shadow[k]);
				k = (k + 1) % (NEURON_BASE + NN * REGION_W);
			end
			wbRead(REG | 8'(STATUS_OFS), st);
		end
	endtask

	task automatic checkResult(input int n);
		logic [31:0] d;
		wbRead(REG | 8'(RESULT_OFS + n), d);
		checkVal($sformatf("RESULT%0d", n), d, refBits(n));
	endtask

	//////////////////////////////////////////////////
	// tests
	//////////////////////////////////////////////////

	task automatic testReset();
		logic [31:0] d;
		repeat (20)
		begin
			@(negedge clk);
			checkVal("ack idle", {31'b0, ack}, 32'd0);
		end
		wbRead(REG | 8'(STATUS_OFS), d);
		checkVal("STATUS", d, 32'd0);
		wbRead(REG | 8'(RESULT_OFS), d);
		checkVal("RESULT0", d, 32'd0);
		wbRead(REG | 8'(RESULT_OFS + 1), d);
		checkVal("RESULT1", d, 32'd0);
	endtask

	task automatic testStore();
		logic [31:0] d;
		for (int a = 0; a < NEURON_BASE + NN * REGION_W; a++)
			if (a != FAN_IN) // word 15 is unused
			begin
				seed = lcgStep(seed);
				wbWrite(8'(a), seed);
			end
		for (int a = 0; a < NEURON_BASE + NN * REGION_W; a++)
			if (a != FAN_IN)
			begin
				wbRead(8'(a), d);
				checkVal($sformatf("store[%0d]", a), d, shadow[a]);
			end
	endtask

	task automatic testNeuron0();
		for (int i = 0; i < FAN_IN; i++)
		begin
			actH[i] = i + 1;
			wH[0][i] = (i % 5) - 2;
		end
		biasH[0] = 3;
		loadActs();
		loadNeuron(0);
		runNeurons(32'd1, 1'b0);
		checkResult(0);
	endtask

	task automatic testRectifier();
		for (int i = 0; i < FAN_IN; i++)
			wH[1][i] = -((i % 3) + 1); // all negative, sum below zero
		biasH[1] = -2;
		loadNeuron(1);
		runNeurons(32'd2, 1'b0);
		checkResult(1);
		checkResult(0); // neuron 0 untouched
	endtask

	task automatic testContention();
		for (int i = 0; i < FAN_IN; i++)
			wH[1][i] = 3 - (i % 4);
		biasH[1] = -5;
		loadNeuron(1);
		runNeurons(32'd3, 1'b1);
		checkResult(0);
		checkResult(1);
	endtask

	task automatic testRandom();
		for (int r = 0; r < 8; r++)
		begin
			for (int i = 0; i < FAN_IN; i++)
			begin
				seed = lcgStep(seed);
				actH[i] = 2 * (int'(seed[19:16]) - 8); // integers, so twice in halves
				for (int n = 0; n < NN; n++)
				begin
					seed = lcgStep(seed);
					wH[n][i] = 2 * (int'(seed[19:16]) - 8);
				end
			end
			for (int n = 0; n < NN; n++)
			begin
				seed = lcgStep(seed);
				biasH[n] = 2 * (int'(seed[19:16]) - 8);
			end
			loadActs();
			loadNeuron(0);
			loadNeuron(1);
			runNeurons(32'd3, 1'b0);
			checkResult(0);
			checkResult(1);
		end
	endtask

	//////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////

	initial
	begin
		arstN = 1'b0;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = '0;
		datW = '0;
		seed = 32'h7412_3e3e;
		cycles = 0;
		checks = 0;
		errors = 0;
		for (int i = 0; i < 128; i++)
			shadow[i] = '0;
		repeat (RESET_CYC) @(negedge clk);
		arstN = 1'b1;

		testReset();
		testStore();
		testNeuron0();
		testRectifier();
		testContention();
		testRandom();

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

/* src/nnLayerTop.sv */
`timescale 1ns/100ps

module nnLayerTop import nnPkg::*; #(
	parameter int NUM_NEURONS = 2
) (
	input  logic                clk,
	input  logic                arstN,
	input  logic                cyc,
	input  logic                stb,
	input  logic                we,
	input  logic [REG_SPACE:0]  adr,
	input  logic [WORD_W-1:0]   datW,
	output logic [WORD_W-1:0]   datR,
	output logic                ack
);

	logic                          hReq;
	logic                          hWe;
	logic [STORE_AW-1:0]           hAddr;
	logic [WORD_W-1:0]             hWdata;
	logic                          hGnt;
	logic [WORD_W-1:0]             hRdata;
	logic [NUM_NEURONS-1:0]        start;
	logic [NUM_NEURONS-1:0]        busy;
	logic [NUM_NEURONS*WORD_W-1:0] result;
	logic [NUM_NEURONS-1:0]        nReq;
	logic [NUM_NEURONS*STORE_AW-1:0] nAddr;
	logic [NUM_NEURONS-1:0]        nGnt;
	logic [WORD_W-1:0]             nRdata;

	hostBridge #(.NUM_NEURONS(NUM_NEURONS)) uBridge (
		.clk(clk), .arstN(arstN),
		.cyc(cyc), .stb(stb), .we(we), .adr(adr), .datW(datW), .datR(datR), .ack(ack),
		.hReq(hReq), .hWe(hWe), .hAddr(hAddr), .hWdata(hWdata),
		.hGnt(hGnt), .hRdata(hRdata),
		.start(start), .busy(busy), .result(result)
	);

	paramStore #(.NUM_NEURONS(NUM_NEURONS)) uStore (
		.clk(clk), .arstN(arstN),
		.hReq(hReq), .hWe(hWe), .hAddr(hAddr), .hWdata(hWdata),
		.hGnt(hGnt), .hRdata(hRdata),
		.nReq(nReq), .nAddr(nAddr), .nGnt(nGnt), .nRdata(nRdata)
	);

	//////////////////////////////////////////////////
	// neurons, one region each
	//////////////////////////////////////////////////
	for (genvar n = 0; n < NUM_NEURONS; n++)
	begin : gNeuron
		neuronUnit #(.BASE(NEURON_BASE + n*REGION_W)) uNeuron (
			.clk(clk),
			.arstN(arstN),
			.start(start[n]),
			.busy(busy[n]),
			.result(result[n*WORD_W +: WORD_W]),
			.req(nReq[n]),
			.addr(nAddr[n*STORE_AW +: STORE_AW]),
			.gnt(nGnt[n]),
			.rdata(nRdata)  // shared read bus
		);
	end

endmodule

/* src/hostBridge.sv */
`timescale 1ns/100ps

module hostBridge import nnPkg::*; #(
	parameter int NUM_NEURONS = 2
) (
	input  logic                          clk,
	input  logic                          arstN,
	input  logic                          cyc,
	input  logic                          stb,
	input  logic                          we,
	input  logic [REG_SPACE:0]            adr,
	input  logic [WORD_W-1:0]             datW,
	output logic [WORD_W-1:0]             datR,
	output logic                          ack,
	output logic                          hReq,
	output logic                          hWe,
	output logic [STORE_AW-1:0]           hAddr,
	output logic [WORD_W-1:0]             hWdata,
	input  logic                          hGnt,
	input  logic [WORD_W-1:0]             hRdata,
	output logic [NUM_NEURONS-1:0]        start,
	input  logic [NUM_NEURONS-1:0]        busy,
	input  logic [NUM_NEURONS*WORD_W-1:0] result
);

	logic                 active;
	logic                 regSel;
	logic                 regAcc;   // register access, first cycle only
	logic                 ctrlWr;
	logic                 storeAck; // current ack came from the store
	logic [REG_SPACE-1:0] offs;
	logic [WORD_W-1:0]    regMux;
	logic [WORD_W-1:0]    regDat;

	assign active = cyc && stb;
	assign regSel = adr[REG_SPACE];
	assign offs = adr[REG_SPACE-1:0];
	assign regAcc = active && regSel && !ack;
	assign ctrlWr = regAcc && we && (offs == REG_SPACE'(CTRL_OFS));

	//////////////////////////////////////////////////
	// store port, held until granted
	//////////////////////////////////////////////////
	assign hReq = active && !regSel && !ack; // !ack stops a second request
	assign hWe = we;
	assign hAddr = adr[STORE_AW-1:0];
	assign hWdata = datW;

	always_comb
	begin
		int ri;
		ri = int'(offs) - RESULT_OFS;
		regMux = '0; // CTRL reads back as zero
		if (offs == REG_SPACE'(STATUS_OFS))
			regMux[NUM_NEURONS-1:0] = busy;
		else if (ri >= 0 && ri < NUM_NEURONS)
			regMux = result[ri*WORD_W +: WORD_W];
	end

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			ack <= 1'b0;
			storeAck <= 1'b0;
			start <= '0;
		end
		else
		begin
			ack <= regAcc || hGnt;
			storeAck <= hGnt;
			start <= ctrlWr ? datW[NUM_NEURONS-1:0] : '0; // one cycle pulse
		end
	end

	always_ff @(posedge clk)
		if (regAcc)
			regDat <= regMux;

	assign datR = storeAck ? hRdata : regDat;

	assert property (@(posedge clk) disable iff (!arstN) ack |=> !ack);

endmodule

/* src/paramStore.sv */
`timescale 1ns/100ps

module paramStore import nnPkg::*; #(
	parameter int NUM_NEURONS = 2
) (
	input  logic                            clk,
	input  logic                            arstN,
	input  logic                            hReq,
	input  logic                            hWe,
	input  logic [STORE_AW-1:0]             hAddr,
	input  logic [WORD_W-1:0]               hWdata,
	output logic                            hGnt,
	output logic [WORD_W-1:0]               hRdata,
	input  logic [NUM_NEURONS-1:0]          nReq,
	input  logic [NUM_NEURONS*STORE_AW-1:0] nAddr,
	output logic [NUM_NEURONS-1:0]          nGnt,
	output logic [WORD_W-1:0]               nRdata
);

	localparam int REQ_N = NUM_NEURONS + 1; // host is index 0
	localparam int PTR_W = $clog2(REQ_N);

	logic [REQ_N-1:0]    reqAll;
	logic [REQ_N-1:0]    gntAll;
	logic [PTR_W-1:0]    lastWin;
	logic [PTR_W-1:0]    winIdx;
	logic                anyGnt;
	logic                doWrite;
	logic [STORE_AW-1:0] selAddr;
	logic [WORD_W-1:0]   rdReg;
	logic [WORD_W-1:0]   mem [2**STORE_AW];

	assign reqAll = {nReq, hReq};

	//////////////////////////////////////////////////
	// round robin, search starts after last winner
	//////////////////////////////////////////////////
	always_comb
	begin
		int cand;
		gntAll = '0;
		winIdx = lastWin;
		anyGnt = 1'b0;
		for (int k = 1; k <= REQ_N; k++)
		begin
			cand = (int'(lastWin) + k) % REQ_N;
			if (!anyGnt && reqAll[cand])
			begin
				anyGnt = 1'b1;
				winIdx = PTR_W'(cand);
				gntAll[cand] = 1'b1;
			end
		end
	end

	always_comb
	begin
		if (winIdx == '0)
			selAddr = hAddr;
		else
			selAddr = nAddr[(int'(winIdx) - 1)*STORE_AW +: STORE_AW];
	end

	assign doWrite = gntAll[0] && hWe; // only the host writes
	assign hGnt = gntAll[0];
	assign nGnt = gntAll[REQ_N-1:1];

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
			lastWin <= PTR_W'(REQ_N - 1); // host wins first
		else if (anyGnt)
			lastWin <= winIdx;
	end

	always_ff @(posedge clk)
	begin
		if (anyGnt)
		begin
			if (doWrite)
				mem[selAddr] <= hWdata;
			else
				rdReg <= mem[selAddr];
		end
	end

	// one read register, only the granted side samples it
	assign hRdata = rdReg;
	assign nRdata = rdReg;

	assert property (@(posedge clk) disable iff (!arstN) $onehot0(gntAll));

endmodule

/* src/neuronUnit.sv */
`timescale 1ns/100ps

module neuronUnit import nnPkg::*; #(
	parameter int BASE = NEURON_BASE
) (
	input  logic                clk,
	input  logic                arstN,
	input  logic                start,
	output logic                busy,
	output logic [WORD_W-1:0]   result,
	output logic                req,
	output logic [STORE_AW-1:0] addr,
	input  logic                gnt,
	input  logic [WORD_W-1:0]   rdata
);

	localparam int IDX_W = $clog2(FAN_IN);

	typedef enum logic [2:0] {
		stIdle,
		stFetchAct,
		stFetchWgt,
		stAccum,
		stFetchBias,
		stAddBias,
		stDone
	} stateT;

	stateT             state;
	logic [IDX_W-1:0]  idx;
	logic              gntD;   // rdata valid this cycle
	logic [WORD_W-1:0] acc;
	logic [WORD_W-1:0] actReg;
	logic [WORD_W-1:0] prod;
	logic [WORD_W-1:0] addB;
	logic [WORD_W-1:0] sum;

	fpMul uMul (
		.a(actReg),
		.b(rdata),
		.p(prod)
	);

	fpAdd uAdd (
		.a(acc),
		.b(addB),
		.s(sum)
	);

	assign busy = (state != stIdle);
	assign addB = (state == stAddBias) ? rdata : prod; // bias goes in unscaled

	always_comb
	begin
		req = 1'b0;
		addr = '0;
		case (state)
			stFetchAct:
			begin
				req = 1'b1;
				addr = STORE_AW'(ACT_BASE) + STORE_AW'(idx);
			end
			stFetchWgt:
			begin
				req = 1'b1;
				addr = STORE_AW'(BASE) + STORE_AW'(idx);
			end
			stFetchBias:
			begin
				req = 1'b1;
				addr = STORE_AW'(BASE + FAN_IN);
			end
			default:
				req = 1'b0;
		endcase
	end

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			state <= stIdle;
			idx <= '0;
			gntD <= 1'b0;
			acc <= '0;
			result <= '0;
		end
		else
		begin
			gntD <= gnt;
			case (state)
				stIdle:
					if (start)
					begin
						acc <= '0;
						idx <= '0;
						state <= stFetchAct;
					end
				stFetchAct:
					if (gnt)
						state <= stFetchWgt;
				stFetchWgt:
					if (gnt)
						state <= stAccum;
				stAccum:
				begin
					acc <= sum;
					if (idx == IDX_W'(FAN_IN - 1))
						state <= stFetchBias;
					else
					begin
						idx <= idx + 1'b1;
						state <= stFetchAct;
					end
				end
				stFetchBias:
					if (gnt)
						state <= stAddBias;
				stAddBias:
				begin
					acc <= sum;
					state <= stDone;
				end
				stDone:
				begin
					result <= acc[WORD_W-1] ? '0 : acc; // rectifier
					state <= stIdle;
				end
				default:
					state <= stIdle;
			endcase
		end
	end

	// activation arrives while the weight request is pending
	always_ff @(posedge clk)
		if (state == stFetchWgt && gntD)
			actReg <= rdata;

	assert property (@(posedge clk) disable iff (!arstN)
		(!busy && !start) |=> !req);

	assert property (@(posedge clk) disable iff (!arstN)
		(req && !gnt) |=> (req && $stable(addr)));

endmodule

/* src/fpAdd.sv */
`timescale 1ns/100ps

module fpAdd import nnPkg::*; (
	input  logic [WORD_W-1:0] a,
	input  logic [WORD_W-1:0] b,
	output logic [WORD_W-1:0] s
);

	logic              aZero;
	logic              bZero;
	logic [WORD_W-1:0] big;
	logic [WORD_W-1:0] lesser;
	logic [7:0]        expDiff;
	logic [23:0]       mBig;
	logic [23:0]       mSmall;
	logic [24:0]       mSum;   // bit 24 holds the carry
	logic [24:0]       mNorm;
	logic [4:0]        lz;
	logic [8:0]        expOut;

	assign aZero = (a[30:23] == 8'd0);
	assign bZero = (b[30:23] == 8'd0);

	always_comb
	begin
		// exponent and fraction compare as one unsigned field
		if (a[30:0] >= b[30:0])
		begin
			big = a;
			lesser = b;
		end
		else
		begin
			big = b;
			lesser = a;
		end

		expDiff = big[30:23] - lesser[30:23];
		mBig = {1'b1, big[22:0]};
		mSmall = {1'b1, lesser[22:0]} >> expDiff; // truncating align

		if (big[31] == lesser[31])
			mSum = {1'b0, mBig} + {1'b0, mSmall};
		else
			mSum = {1'b0, mBig} - {1'b0, mSmall};

		//////////////////////////////////////////////////
		// normalize so the leading one ends up at bit 24
		//////////////////////////////////////////////////
		lz = 5'd0;
		for (int i = 0; i < 25; i++)
			if (mSum[i])
				lz = 5'(24 - i);
		mNorm = mSum << lz;
		expOut = {1'b0, big[30:23]} + 9'd1 - {4'b0000, lz};

		if (aZero)
			s = bZero ? '0 : b;
		else if (bZero)
			s = a;
		else if (mSum == '0)
			s = '0; // exact cancellation gives +0
		else if (expOut[8] || expOut == 9'd0)
			s = '0;
		else
			s = {big[31], expOut[7:0], mNorm[23:1]};
	end

endmodule

/* src/fpMul.sv */
`timescale 1ns/100ps

module fpMul import nnPkg::*; (
	input  logic [WORD_W-1:0] a,
	input  logic [WORD_W-1:0] b,
	output logic [WORD_W-1:0] p
);

	logic        sign;
	logic        zeroIn;
	logic [47:0] mantProd;
	logic [9:0]  expSum;  // two spare bits for under and overflow
	logic [9:0]  expNorm;
	logic [22:0] frac;

	assign zeroIn = (a[30:23] == 8'd0) || (b[30:23] == 8'd0); // denormals count as zero

	always_comb
	begin
		sign = a[31] ^ b[31];
		mantProd = {1'b1, a[22:0]} * {1'b1, b[22:0]};
		expSum = {2'b00, a[30:23]} + {2'b00, b[30:23]} - 10'd127;

		// product of two 1.x mantissas lies in [1, 4)
		if (mantProd[47])
		begin
			frac = mantProd[46:24];
			expNorm = expSum + 10'd1;
		end
		else
		begin
			frac = mantProd[45:23];
			expNorm = expSum;
		end

		if (zeroIn)
			p = '0;
		else if (expNorm[9] || expNorm == 10'd0)
			p = '0; // underflow flushes to zero
		else
			p = {sign, expNorm[7:0], frac};
	end

endmodule

/* src/nnPkg.sv */
package nnPkg;

	//////////////////////////////////////////////////
	// data sizes
	//////////////////////////////////////////////////

	localparam int WORD_W = 32; // one float, one bus word
	localparam int FAN_IN = 15; // inputs per neuron

	//////////////////////////////////////////////////
	// store address map, in words
	//////////////////////////////////////////////////

	localparam int STORE_AW = 7; // 128 words

	localparam int ACT_BASE = 0; // activations 0 .. FAN_IN-1

	// one region per neuron: weights first, bias last
	localparam int NEURON_BASE = 16;
	localparam int REGION_W = 16;

	//////////////////////////////////////////////////
	// wishbone register space
	//////////////////////////////////////////////////

	// adr bit that selects registers over the store
	localparam int REG_SPACE = 7;

	localparam int CTRL_OFS = 0;   // write 1 to bit n starts neuron n
	localparam int STATUS_OFS = 1; // bit n is busy of neuron n
	localparam int RESULT_OFS = 2; // plus n for neuron n

endpackage
